// File: src/chromaPkg.sv
package chromaPkg;

    // --------------------
    // Plane geometry
    // --------------------
    localparam int PLANE_DIM   = 8;
    localparam int BLK_DIM     = 4;
    localparam int NUM_BLOCKS  = 4;
    localparam int BLK_PIX     = 16;
    localparam int BLK_PER_ROW = PLANE_DIM / BLK_DIM;

    // --------------------
    // Sample and coefficient types
    // --------------------
    typedef logic        [7:0]  pixelT;
    typedef logic signed [8:0]  residT;
    typedef logic signed [15:0] coefT;
    typedef logic        [3:0]  shiftT;
    typedef logic [$clog2(NUM_BLOCKS)-1:0] blkIdxT;

    // One 4x4 block, index is row * 4 + column
    typedef pixelT [BLK_PIX-1:0] blockPixT;
    typedef residT [BLK_PIX-1:0] blockResidT;
    typedef coefT  [BLK_PIX-1:0] blockCoefT;

    // Whole plane, pixel index is row * 8 + column
    typedef pixelT [PLANE_DIM*PLANE_DIM-1:0] planePixT;

    // Levels stored block after block
    typedef coefT [NUM_BLOCKS*BLK_PIX-1:0] planeCoefT;

endpackage

// File: src/wbPkg.sv
package wbPkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int WB_ADR_W = 2;
    localparam int WB_DAT_W = 8;

    typedef logic [WB_ADR_W-1:0] wbAdrT;
    typedef logic [WB_DAT_W-1:0] wbDatT;

    // --------------------
    // Register map
    // --------------------
    localparam wbAdrT REG_DC_SHIFT = 2'd0;
    localparam wbAdrT REG_AC_SHIFT = 2'd1;
    localparam wbAdrT REG_STATUS   = 2'd2;

    // Read-only status bits
    localparam int STATUS_BUSY_BIT = 0;

endpackage

// File: src/coefStreamIf.sv
`timescale 1ns/10ps

interface coefStreamIf import chromaPkg::*; ();

    // One 4x4 block per valid cycle, no back-pressure
    logic      valid;
    blkIdxT    blkIdx;
    blockCoefT coefs;

    // Any level of the block is non-zero
    logic      nz;

    modport src (
        output valid,
        output blkIdx,
        output coefs,
        output nz
    );

    modport dst (
        input valid,
        input blkIdx,
        input coefs,
        input nz
    );

endinterface

// File: src/hadamard4x4.sv
`timescale 1ns/10ps

module hadamard4x4 import chromaPkg::*; #(
    parameter type inT     = residT,
    parameter type outT    = coefT,
    parameter bit  INVERSE = 1'b0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              valid_i,
    input  blkIdxT            blkIdx_i,
    input  logic              nz_i,
    input  inT [BLK_PIX-1:0]  in_i,
    coefStreamIf.src          out_o
);

    int                 rowW [BLK_PIX];
    int                 colW [BLK_PIX];
    outT [BLK_PIX-1:0]  resW;

    // Row pass, X * H
    always_comb begin
        int a, b, c, d;
        for (int r = 0; r < BLK_DIM; r++) begin
            a = $signed(in_i[r*BLK_DIM+0]) + $signed(in_i[r*BLK_DIM+1]);
            b = $signed(in_i[r*BLK_DIM+0]) - $signed(in_i[r*BLK_DIM+1]);
            c = $signed(in_i[r*BLK_DIM+2]) + $signed(in_i[r*BLK_DIM+3]);
            d = $signed(in_i[r*BLK_DIM+2]) - $signed(in_i[r*BLK_DIM+3]);
            rowW[r*BLK_DIM+0] = a + c;
            rowW[r*BLK_DIM+1] = b + d;
            rowW[r*BLK_DIM+2] = a - c;
            rowW[r*BLK_DIM+3] = b - d;
        end
    end

    // Column pass, H * (X * H)
    always_comb begin
        int a, b, c, d;
        for (int k = 0; k < BLK_DIM; k++) begin
            a = rowW[k] + rowW[BLK_DIM+k];
            b = rowW[k] - rowW[BLK_DIM+k];
            c = rowW[2*BLK_DIM+k] + rowW[3*BLK_DIM+k];
            d = rowW[2*BLK_DIM+k] - rowW[3*BLK_DIM+k];
            colW[k]           = a + c;
            colW[BLK_DIM+k]   = b + d;
            colW[2*BLK_DIM+k] = a - c;
            colW[3*BLK_DIM+k] = b - d;
        end
    end

    // Inverse divides by 16 with rounding
    always_comb begin
        for (int i = 0; i < BLK_PIX; i++) begin
            if (INVERSE) begin
                resW[i] = outT'((colW[i] + 8) >>> 4);
            end else begin
                resW[i] = outT'(colW[i]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_o.valid <= 1'b0;
        end else begin
            out_o.valid <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            out_o.blkIdx <= blkIdx_i;
            out_o.nz     <= nz_i;
            out_o.coefs  <= resW;
        end
    end

endmodule

// File: src/blockQuantizer.sv
`timescale 1ns/10ps

module blockQuantizer import chromaPkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    coefStreamIf.dst   coefIn,
    coefStreamIf.src   deqOut,
    input  shiftT      dcShift_i,
    input  shiftT      acShift_i,
    output blockCoefT  levels_o,
    output logic       levelsValid_o,
    output blkIdxT     levelsIdx_o
);

    blockCoefT levelW;
    blockCoefT deqW;
    logic      nzW;
    logic      validR;
    blkIdxT    idxR;

    // Sign and magnitude shift, DC uses its own amount
    always_comb begin
        shiftT sh;
        int    mag;
        int    lvl;
        logic  neg;
        nzW = 1'b0;
        for (int i = 0; i < BLK_PIX; i++) begin
            sh        = (i == 0) ? dcShift_i : acShift_i;
            mag       = $signed(coefIn.coefs[i]);
            neg       = mag < 0;
            lvl       = (neg ? -mag : mag) >> sh;
            lvl       = neg ? -lvl : lvl;
            levelW[i] = coefT'(lvl);
            deqW[i]   = coefT'(lvl <<< sh);
            nzW       = nzW | (lvl != 0);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            validR <= 1'b0;
        end else begin
            validR <= coefIn.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (coefIn.valid) begin
            idxR         <= coefIn.blkIdx;
            levels_o     <= levelW;
            deqOut.coefs <= deqW;
            deqOut.nz    <= nzW;
        end
    end

    assign deqOut.valid  = validR;
    assign deqOut.blkIdx = idxR;
    assign levelsValid_o = validR;
    assign levelsIdx_o   = idxR;

endmodule

// File: src/quantRegs.sv
`timescale 1ns/10ps

module quantRegs import chromaPkg::*, wbPkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   wbCyc_i,
    input  logic   wbStb_i,
    input  logic   wbWe_i,
    input  wbAdrT  wbAdr_i,
    input  wbDatT  wbDat_i,
    output wbDatT  wbDat_o,
    output logic   wbAck_o,
    input  logic   busy_i,
    output shiftT  dcShift_o,
    output shiftT  acShift_o
);

    logic  reqW;
    wbDatT readW;

    // New request only when no ack is pending
    assign reqW = wbCyc_i && wbStb_i && !wbAck_o;

    always_comb begin
        readW = '0;
        case (wbAdr_i)
            REG_DC_SHIFT: readW = wbDatT'(dcShift_o);
            REG_AC_SHIFT: readW = wbDatT'(acShift_o);
            REG_STATUS:   readW[STATUS_BUSY_BIT] = busy_i;
            default:      readW = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wbAck_o   <= 1'b0;
            dcShift_o <= '0;
            acShift_o <= '0;
        end else begin
            wbAck_o <= reqW;
            if (reqW && wbWe_i) begin
                case (wbAdr_i)
                    REG_DC_SHIFT: dcShift_o <= wbDat_i[$bits(shiftT)-1:0];
                    REG_AC_SHIFT: acShift_o <= wbDat_i[$bits(shiftT)-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (reqW && !wbWe_i) begin
            wbDat_o <= readW;
        end
    end

endmodule

// File: src/reconstructUv.sv
`timescale 1ns/10ps

module reconstructUv import chromaPkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  planePixT               srcPix_i,
    input  planePixT               predPix_i,
    output blockResidT             resid_o,
    output logic                   residValid_o,
    output blkIdxT                 residIdx_o,
    input  blockCoefT              levels_i,
    input  logic                   levelsValid_i,
    input  blkIdxT                 levelsIdx_i,
    coefStreamIf.dst               recIn,
    output planePixT               recon_o,
    output planeCoefT              levels_o,
    output logic [NUM_BLOCKS-1:0]  nz_o,
    output logic                   busy_o,
    output logic                   done_o
);

    logic     issueActive;
    blkIdxT   issueCnt;
    blockPixT srcBlk;
    blockPixT predBlk;
    blockPixT reconBlk;
    logic     lastBlock;

    // Plane index of pixel i of block blk
    function automatic int pixPos(blkIdxT blk, int i);
        return (BLK_DIM * (int'(blk) / BLK_PER_ROW) + i / BLK_DIM) * PLANE_DIM
             + BLK_DIM * (int'(blk) % BLK_PER_ROW) + i % BLK_DIM;
    endfunction

    function automatic pixelT clampPix(int v);
        if (v < 0) begin
            return '0;
        end else if (v > 255) begin
            return '1;
        end
        return pixelT'(v);
    endfunction

    // --------------------
    // Block issue
    // --------------------
    always_comb begin
        for (int i = 0; i < BLK_PIX; i++) begin
            srcBlk[i]  = srcPix_i[pixPos(issueCnt, i)];
            predBlk[i] = predPix_i[pixPos(issueCnt, i)];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issueActive  <= 1'b0;
            issueCnt     <= '0;
            residValid_o <= 1'b0;
        end else begin
            residValid_o <= issueActive;
            if (start_i && !busy_o) begin
                issueActive <= 1'b1;
                issueCnt    <= '0;
            end else if (issueActive) begin
                issueCnt <= issueCnt + 1'b1;
                if (issueCnt == blkIdxT'(NUM_BLOCKS - 1)) begin
                    issueActive <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issueActive) begin
            residIdx_o <= issueCnt;
            for (int i = 0; i < BLK_PIX; i++) begin
                resid_o[i] <= $signed({1'b0, srcBlk[i]}) - $signed({1'b0, predBlk[i]});
            end
        end
    end

    // --------------------
    // Collect results
    // --------------------
    always_comb begin
        for (int i = 0; i < BLK_PIX; i++) begin
            reconBlk[i] = clampPix(int'(predPix_i[pixPos(recIn.blkIdx, i)])
                                   + int'($signed(recIn.coefs[i])));
        end
    end

    always_ff @(posedge clk) begin
        if (levelsValid_i) begin
            levels_o[levelsIdx_i*BLK_PIX +: BLK_PIX] <= levels_i;
        end
        if (recIn.valid) begin
            for (int i = 0; i < BLK_PIX; i++) begin
                recon_o[pixPos(recIn.blkIdx, i)] <= reconBlk[i];
            end
        end
    end

    // Fourth block back ends the run
    assign lastBlock = recIn.valid && (recIn.blkIdx == blkIdxT'(NUM_BLOCKS - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_o <= 1'b0;
            done_o <= 1'b0;
            nz_o   <= '0;
        end else begin
            done_o <= lastBlock;
            if (lastBlock) begin
                busy_o <= 1'b0;
            end else if (start_i && !busy_o) begin
                busy_o <= 1'b1;
            end
            if (recIn.valid) begin
                nz_o[recIn.blkIdx] <= recIn.nz;
            end
        end
    end

endmodule

// File: src/chromaRecon.sv
`timescale 1ns/10ps

module chromaRecon import chromaPkg::*, wbPkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  planePixT               srcPix_i,
    input  planePixT               predPix_i,
    output planePixT               recon_o,
    output planeCoefT              levels_o,
    output logic [NUM_BLOCKS-1:0]  nz_o,
    output logic                   busy_o,
    output logic                   done_o,
    input  logic                   wbCyc_i,
    input  logic                   wbStb_i,
    input  logic                   wbWe_i,
    input  wbAdrT                  wbAdr_i,
    input  wbDatT                  wbDat_i,
    output wbDatT                  wbDat_o,
    output logic                   wbAck_o
);

    blockResidT resid;
    logic       residValid;
    blkIdxT     residIdx;
    blockCoefT  levels;
    logic       levelsValid;
    blkIdxT     levelsIdx;
    shiftT      dcShift;
    shiftT      acShift;

    coefStreamIf fwdStream ();
    coefStreamIf deqStream ();
    coefStreamIf recStream ();

    quantRegs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .wbCyc_i   (wbCyc_i),
        .wbStb_i   (wbStb_i),
        .wbWe_i    (wbWe_i),
        .wbAdr_i   (wbAdr_i),
        .wbDat_i   (wbDat_i),
        .wbDat_o   (wbDat_o),
        .wbAck_o   (wbAck_o),
        .busy_i    (busy_o),
        .dcShift_o (dcShift),
        .acShift_o (acShift)
    );

    reconstructUv u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_i       (start_i),
        .srcPix_i      (srcPix_i),
        .predPix_i     (predPix_i),
        .resid_o       (resid),
        .residValid_o  (residValid),
        .residIdx_o    (residIdx),
        .levels_i      (levels),
        .levelsValid_i (levelsValid),
        .levelsIdx_i   (levelsIdx),
        .recIn         (recStream.dst),
        .recon_o       (recon_o),
        .levels_o      (levels_o),
        .nz_o          (nz_o),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    // --------------------
    // Pipeline
    // --------------------
    hadamard4x4 #(.inT(residT), .outT(coefT), .INVERSE(1'b0)) u_fwd (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (residValid),
        .blkIdx_i (residIdx),
        .nz_i     (1'b0),
        .in_i     (resid),
        .out_o    (fwdStream.src)
    );

    blockQuantizer u_quant (
        .clk           (clk),
        .rst_n         (rst_n),
        .coefIn        (fwdStream.dst),
        .deqOut        (deqStream.src),
        .dcShift_i     (dcShift),
        .acShift_i     (acShift),
        .levels_o      (levels),
        .levelsValid_o (levelsValid),
        .levelsIdx_o   (levelsIdx)
    );

    hadamard4x4 #(.inT(coefT), .outT(coefT), .INVERSE(1'b1)) u_inv (
        .clk      (clk),
        .rst_n    (rst_n),
        .valid_i  (deqStream.valid),
        .blkIdx_i (deqStream.blkIdx),
        .nz_i     (deqStream.nz),
        .in_i     (deqStream.coefs),
        .out_o    (recStream.src)
    );

endmodule

// File: tb/chromaRecon_assertions.sv
`timescale 1ns/10ps

module chromaReconAssertions import chromaPkg::*; (
    input logic  clk,
    input logic  rst_n,
    input logic  busy_i,
    input logic  done_i,
    input logic  fwdValid_i,
    input shiftT dcShift_i,
    input shiftT acShift_i
);

    int unsigned failCount = 0;

    // --------------------
    // Run control
    // --------------------
    donePulse: assert property (@(posedge clk) disable iff (!rst_n) done_i |=> !done_i)
        else begin
            $error("done_i stayed high for more than one cycle");
            failCount++;
        end

    busyEndsAtDone: assert property (@(posedge clk) disable iff (!rst_n)
                                     $rose(done_i) |-> $fell(busy_i))
        else begin
            $error("done_i rose while busy_i did not fall");
            failCount++;
        end

    doneEndsBusy: assert property (@(posedge clk) disable iff (!rst_n)
                                   $fell(busy_i) |-> $rose(done_i))
        else begin
            $error("busy_i fell without done_i rising");
            failCount++;
        end

    // Host keeps the quantizer shifts still during a run
    shiftHold: assert property (@(posedge clk) disable iff (!rst_n)
                                busy_i |-> $stable(dcShift_i) && $stable(acShift_i))
        else begin
            $error("shift register changed while busy");
            failCount++;
        end

    // Four blocks back to back on the forward stream
    fwdBurst: assert property (@(posedge clk) disable iff (!rst_n)
                               $fell(fwdValid_i) |-> $past(fwdValid_i, 2)
                               && $past(fwdValid_i, 3) && $past(fwdValid_i, 4)
                               && !$past(fwdValid_i, 5))
        else begin
            $error("forward stream burst is not four cycles long");
            failCount++;
        end

endmodule

// File: tb/tbChromaRecon.sv
`timescale 1ns/10ps

module tbChromaRecon import chromaPkg::*, wbPkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int RUN_EDGES  = 8;
    localparam int RUN_LIMIT  = 20;
    localparam int NUM_ROWS   = 7;
    localparam int WATCHDOG_CYCLES = (NUM_ROWS + 1) * 40 + (2 * NUM_ROWS + 10) * 6 + 40;

    typedef enum logic [1:0] {MODE_RAND, MODE_FLAT, MODE_SAME} modeT;

    typedef struct packed {
        shiftT                 dcShift;
        shiftT                 acShift;
        modeT                  mode;
        logic                  nzFixed;
        logic [NUM_BLOCKS-1:0] nzExp;
    } rowT;

    // dcShift, acShift, sample mode, nz fixed, expected nz
    rowT stimRows [NUM_ROWS] = '{
        '{4'd0,  4'd0,  MODE_RAND, 1'b0, 4'h0},
        '{4'd0,  4'd0,  MODE_FLAT, 1'b1, 4'hF},
        '{4'd3,  4'd2,  MODE_RAND, 1'b0, 4'h0},
        '{4'd5,  4'd4,  MODE_RAND, 1'b0, 4'h0},
        '{4'd2,  4'd6,  MODE_SAME, 1'b1, 4'h0},
        '{4'd15, 4'd15, MODE_RAND, 1'b1, 4'h0},
        '{4'd1,  4'd3,  MODE_FLAT, 1'b1, 4'hF}
    };

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    planePixT              srcPix;
    planePixT              predPix;
    planePixT              recon;
    planeCoefT             levels;
    logic [NUM_BLOCKS-1:0] nz;
    logic                  busy;
    logic                  done;
    logic                  wbCyc;
    logic                  wbStb;
    logic                  wbWe;
    wbAdrT                 wbAdr;
    wbDatT                 wbDatW;
    wbDatT                 wbDatR;
    logic                  wbAck;

    logic [31:0] lcgState = 32'd79;
    shiftT       curDc;
    shiftT       curAc;
    int          doneCnt = 0;
    int          testsRun = 0;
    int          testsFailed = 0;
    int          errors = 0;

    chromaRecon u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .start_i   (start),
        .srcPix_i  (srcPix),
        .predPix_i (predPix),
        .recon_o   (recon),
        .levels_o  (levels),
        .nz_o      (nz),
        .busy_o    (busy),
        .done_o    (done),
        .wbCyc_i   (wbCyc),
        .wbStb_i   (wbStb),
        .wbWe_i    (wbWe),
        .wbAdr_i   (wbAdr),
        .wbDat_i   (wbDatW),
        .wbDat_o   (wbDatR),
        .wbAck_o   (wbAck)
    );

    // Run control, shift and forward stream checks
    bind chromaRecon chromaReconAssertions u_assert (
        .clk        (clk),
        .rst_n      (rst_n),
        .busy_i     (busy_o),
        .done_i     (done_o),
        .fwdValid_i (fwdStream.valid),
        .dcShift_i  (dcShift),
        .acShift_i  (acShift)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    always @(negedge clk) begin
        if (done) begin
            doneCnt++;
        end
    end

    function automatic pixelT lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[23:16];
    endfunction

    // Entry of the order-4 Hadamard matrix
    function automatic int hSign(int i, int j);
        return ($countones(i & j) % 2 == 1) ? -1 : 1;
    endfunction

    // --------------------
    // Reference model
    // --------------------
    task automatic refModel(input planePixT src, input planePixT pred, input shiftT dcS,
                            input shiftT acS, output planePixT expRecon,
                            output planeCoefT expLevels, output logic [NUM_BLOCKS-1:0] expNz);
        int x [BLK_PIX];
        int d [BLK_PIX];
        int pos;
        int acc;
        int sh;
        int lvl;
        int v;
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            expNz[b] = 1'b0;
            for (int i = 0; i < BLK_PIX; i++) begin
                pos  = (4 * (b / 2) + i / 4) * PLANE_DIM + 4 * (b % 2) + i % 4;
                x[i] = int'(src[pos]) - int'(pred[pos]);
            end
            for (int u = 0; u < BLK_DIM; u++) begin
                for (int w = 0; w < BLK_DIM; w++) begin
                    acc = 0;
                    for (int r = 0; r < BLK_DIM; r++) begin
                        for (int c = 0; c < BLK_DIM; c++) begin
                            acc += hSign(u, r) * x[r*4+c] * hSign(c, w);
                        end
                    end
                    sh  = (u == 0 && w == 0) ? int'(dcS) : int'(acS);
                    lvl = ((acc < 0) ? -acc : acc) >> sh;
                    lvl = (acc < 0) ? -lvl : lvl;
                    expLevels[b*BLK_PIX+u*4+w] = coefT'(lvl);
                    expNz[b] = expNz[b] | (lvl != 0);
                    d[u*4+w] = lvl <<< sh;
                end
            end
            for (int r = 0; r < BLK_DIM; r++) begin
                for (int c = 0; c < BLK_DIM; c++) begin
                    acc = 0;
                    for (int u = 0; u < BLK_DIM; u++) begin
                        for (int w = 0; w < BLK_DIM; w++) begin
                            acc += hSign(r, u) * d[u*4+w] * hSign(w, c);
                        end
                    end
                    pos = (4 * (b / 2) + r) * PLANE_DIM + 4 * (b % 2) + c;
                    v   = int'(pred[pos]) + ((acc + 8) >>> 4);
                    expRecon[pos] = pixelT'((v < 0) ? 0 : ((v > 255) ? 255 : v));
                end
            end
        end
    endtask

    // --------------------
    // Bus and run tasks
    // --------------------
    task automatic wbAccess(input logic we, input wbAdrT adr, input wbDatT din,
                            output wbDatT dout, inout int bad);
        int waitCnt;
        int acks;
        waitCnt = 0;
        acks    = 0;
        dout    = '0;
        @(posedge clk);
        wbCyc  <= 1'b1;
        wbStb  <= 1'b1;
        wbWe   <= we;
        wbAdr  <= adr;
        wbDatW <= din;
        while (acks == 0 && waitCnt < 8) begin
            @(negedge clk);
            waitCnt++;
            if (wbAck) begin
                acks++;
                dout = wbDatR;
            end
        end
        @(posedge clk);
        wbCyc <= 1'b0;
        wbStb <= 1'b0;
        wbWe  <= 1'b0;
        @(negedge clk);
        if (wbAck) begin
            acks++;
        end
        if (acks != 1) begin
            $display("Error at %0t: %0d acks on register %0d, expected 1", $time, acks, adr);
            bad++;
        end
    endtask

    task automatic fillPlanes(input modeT mode);
        pixelT s;
        pixelT p;
        @(posedge clk);
        for (int i = 0; i < PLANE_DIM * PLANE_DIM; i++) begin
            case (mode)
                MODE_FLAT: begin
                    s = 8'd200;
                    p = 8'd50;
                end
                MODE_SAME: begin
                    s = lcgNext();
                    p = s;
                end
                default: begin
                    s = lcgNext();
                    p = lcgNext();
                end
            endcase
            srcPix[i]  <= s;
            predPix[i] <= p;
        end
    endtask

    // Counts edges from the start edge until done is seen, and how many of them saw busy
    task automatic runPlane(output int edges, output int busyEdges);
        logic seen;
        seen      = 1'b0;
        edges     = 0;
        busyEdges = 0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!seen && edges < RUN_LIMIT) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            seen = done;
            if (busy) begin
                busyEdges++;
            end
        end
        if (!seen) begin
            $display("Timeout: done_o did not rise within %0d edges of the start", RUN_LIMIT);
        end
    endtask

    task automatic reportTest(input string name, input int bad);
        testsRun++;
        errors += bad;
        if (bad == 0) begin
            $display("%0t: %s ok", $time, name);
        end else begin
            testsFailed++;
            $display("%0t: %s failed with %0d errors", $time, name, bad);
        end
    endtask

    task automatic checkRun(input string name, input int edges, input int busyEdges,
                            input logic nzFixed, input logic [NUM_BLOCKS-1:0] nzExp,
                            input int bad);
        planePixT              expRecon;
        planeCoefT             expLevels;
        logic [NUM_BLOCKS-1:0] expNz;
        refModel(srcPix, predPix, curDc, curAc, expRecon, expLevels, expNz);
        if (edges != RUN_EDGES) begin
            $display("Error at %0t: %s done after %0d edges, expected %0d",
                     $time, name, edges, RUN_EDGES);
            bad++;
        end
        // Busy from the start edge until done rises
        if (busyEdges != RUN_EDGES - 1) begin
            $display("Error at %0t: %s busy seen on %0d edges, expected %0d",
                     $time, name, busyEdges, RUN_EDGES - 1);
            bad++;
        end
        if (levels !== expLevels) begin
            $display("Error at %0t: %s levels differ from the reference", $time, name);
            bad++;
        end
        if (nz !== expNz || (nzFixed && nz !== nzExp)) begin
            $display("Error at %0t: %s nz is %h, expected %h", $time, name, nz, expNz);
            bad++;
        end
        if (recon !== expRecon) begin
            $display("Error at %0t: %s recon differs from the reference", $time, name);
            bad++;
        end
        if (curDc == 0 && curAc == 0 && recon !== srcPix) begin
            $display("Error at %0t: %s recon differs from the source", $time, name);
            bad++;
        end
        reportTest(name, bad);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int    bad;
        int    edges;
        int    busyEdges;
        int    doneBefore;
        wbDatT rd;
        $timeformat(-9, 0, " ns", 0);
        rst_n   = 1'b0;
        start   = 1'b0;
        srcPix  = '0;
        predPix = '0;
        wbCyc   = 1'b0;
        wbStb   = 1'b0;
        wbWe    = 1'b0;
        wbAdr   = '0;
        wbDatW  = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        bad = 0;
        wbAccess(1'b1, REG_DC_SHIFT, 8'h05, rd, bad);
        wbAccess(1'b1, REG_AC_SHIFT, 8'h09, rd, bad);
        wbAccess(1'b0, REG_DC_SHIFT, 8'h00, rd, bad);
        if (rd !== 8'h05) begin
            $display("Error at %0t: DC shift reads %h, expected 05", $time, rd);
            bad++;
        end
        wbAccess(1'b0, REG_AC_SHIFT, 8'h00, rd, bad);
        if (rd !== 8'h09) begin
            $display("Error at %0t: AC shift reads %h, expected 09", $time, rd);
            bad++;
        end
        wbAccess(1'b0, REG_STATUS, 8'h00, rd, bad);
        if (rd[STATUS_BUSY_BIT] !== 1'b0) begin
            $display("Error at %0t: status reads busy while idle", $time);
            bad++;
        end
        reportTest("register access", bad);

        for (int n = 0; n < NUM_ROWS; n++) begin
            bad   = 0;
            curDc = stimRows[n].dcShift;
            curAc = stimRows[n].acShift;
            wbAccess(1'b1, REG_DC_SHIFT, wbDatT'(curDc), rd, bad);
            wbAccess(1'b1, REG_AC_SHIFT, wbDatT'(curAc), rd, bad);
            fillPlanes(stimRows[n].mode);
            runPlane(edges, busyEdges);
            checkRun($sformatf("row %0d", n), edges, busyEdges, stimRows[n].nzFixed,
                     stimRows[n].nzExp, bad);
        end

        // Second start during the run must be dropped
        bad = 0;
        fillPlanes(MODE_RAND);
        doneBefore = doneCnt;
        fork
            runPlane(edges, busyEdges);
            begin
                @(posedge clk);
                wbAccess(1'b0, REG_STATUS, 8'h00, rd, bad);
                if (rd[STATUS_BUSY_BIT] !== 1'b1) begin
                    $display("Error at %0t: status reads idle during a run", $time);
                    bad++;
                end
                @(posedge clk);
                start <= 1'b1;
                @(posedge clk);
                start <= 1'b0;
            end
        join
        repeat (12) @(posedge clk);
        if (doneCnt - doneBefore != 1) begin
            $display("Error at %0t: %0d done pulses for one run", $time, doneCnt - doneBefore);
            bad++;
        end
        checkRun("start while busy", edges, busyEdges, 1'b0, 4'h0, bad);

        $display("Tests %0d, failed %0d, errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, u_dut.u_assert.failCount);
        if (errors == 0 && testsFailed == 0 && u_dut.u_assert.failCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
src/chromaPkg.sv
src/wbPkg.sv
src/coefStreamIf.sv
src/hadamard4x4.sv
src/blockQuantizer.sv
src/quantRegs.sv
src/reconstructUv.sv
src/chromaRecon.sv
tb/chromaRecon_assertions.sv
tb/tbChromaRecon.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the chroma reconstruction testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert --top-module tbChromaRecon -f files.f -o simChromaRecon &&
./obj_dir/simChromaRecon | tee /dev/stderr | grep -q "TESTBENCH PASSED" &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }
